// File: logic/fir_settings.svh
`ifndef FIR_SETTINGS_SVH
`define FIR_SETTINGS_SVH

// filter size
`define FIR_NUM_TAPS 11

// bus widths
`define FIR_DATA_W 32
`define FIR_ADDR_W 12

// register map, byte offsets
`define FIR_REG_AP_CTRL  12'h000
`define FIR_REG_TAP_BASE 12'h080  // one word per tap, stride 4

`endif

// File: logic/fir_pkg.sv
`default_nettype none

`include "fir_settings.svh"

package fir_pkg;

  // bits needed to index every tap
  localparam int tap_idx_w = $clog2(`FIR_NUM_TAPS);

  typedef logic [`FIR_DATA_W-1:0] word_t;  // sample, coefficient or result
  typedef logic [`FIR_ADDR_W-1:0] addr_t;
  typedef logic [tap_idx_w-1:0]   tap_idx_t;

  // filter run state, mirrored in ap_ctrl
  typedef enum logic [1:0] {
    run_idle = 2'd0,
    run_busy = 2'd1,
    run_done = 2'd2
  } run_state_t;

endpackage

`default_nettype wire

// File: logic/fir_mac_if.sv
`timescale 1ns/1ps
`default_nettype none

// one beat = one sample/coef product term
interface fir_mac_if import fir_pkg::*; ();

  logic  valid;
  logic  ready;
  word_t sample;
  word_t coef;
  logic  last_tap;    // final term of one output
  logic  frame_last;  // term belongs to the tlast sample

  modport source (
    output valid, sample, coef, last_tap, frame_last,
    input  ready
  );

  modport sink (
    input  valid, sample, coef, last_tap, frame_last,
    output ready
  );

endinterface

`default_nettype wire

// File: logic/fir_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "fir_settings.svh"

module fir_cfg_regs import fir_pkg::*; (
  input  wire        axis_clk,
  input  wire        axis_rst_n,
  // write channel
  input  wire        awvalid,
  input  wire addr_t awaddr,
  input  wire        wvalid,
  input  wire word_t wdata,
  output logic       awready,
  output logic       wready,
  // read channel
  input  wire        arvalid,
  input  wire addr_t araddr,
  output logic       arready,
  output logic       rvalid,
  output word_t      rdata,
  input  wire        rready,
  // coefficient lookup from the window stage
  input  wire tap_idx_t coef_idx,
  output word_t      coef,
  // run control
  input  wire        frame_done,
  output logic       busy
);

  localparam int n_taps = `FIR_NUM_TAPS;

  run_state_t run_state;
  word_t      taps [n_taps];
  word_t      rd_word;
  logic       wr_fire;
  logic       rd_fire;
  logic       wr_tap_ok;

  function automatic logic is_tap(addr_t a);
    return (a >= `FIR_REG_TAP_BASE) && (a < `FIR_REG_TAP_BASE + 4 * n_taps)
      && (a[1:0] == 2'b00);
  endfunction

  function automatic tap_idx_t tap_index(addr_t a);
    addr_t off;
    off = a - `FIR_REG_TAP_BASE;
    return off[tap_idx_w+1:2];
  endfunction

  assign wr_fire = awready & awvalid & wvalid;
  assign rd_fire = arready & arvalid;
  assign busy    = (run_state == run_busy);
  assign coef    = taps[coef_idx];  // async lookup

  // ready pulses, write wins over read
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      arready <= 1'b0;
    end else begin
      awready <= awvalid & wvalid & ~awready;
      wready  <= awvalid & wvalid & ~awready;
      arready <= arvalid & ~awvalid & ~wvalid & ~rvalid & ~arready;
    end
  end

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      rvalid <= 1'b0;
    end else if (rd_fire) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge axis_clk) begin
    if (rd_fire) rdata <= rd_word;
  end

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      run_state <= run_idle;
    end else begin
      case (run_state)
        run_idle: if (wr_fire && awaddr == `FIR_REG_AP_CTRL && wdata[0]) run_state <= run_busy;
        run_busy: if (frame_done) run_state <= run_done;
        run_done: if (rd_fire && araddr == `FIR_REG_AP_CTRL) run_state <= run_idle;
        default:  run_state <= run_idle;
      endcase
    end
  end

  assign wr_tap_ok = wr_fire & is_tap(awaddr) & ~busy;  // taps frozen during a run

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      for (int i = 0; i < n_taps; i++) taps[i] <= '0;
    end else if (wr_tap_ok) begin
      taps[tap_index(awaddr)] <= wdata;
    end
  end

  // ap_ctrl = {idle, done, start(reads 0)}
  always_comb begin
    rd_word = '1;
    if (araddr == `FIR_REG_AP_CTRL) begin
      rd_word = '0;
      rd_word[1] = (run_state == run_done);
      rd_word[2] = ~busy;
    end else if (is_tap(araddr) && !busy) begin
      rd_word = taps[tap_index(araddr)];
    end
  end

  a_no_rd_wr_overlap: assert property (
    @(posedge axis_clk) disable iff (!axis_rst_n) !(awready && arready)
  ) else $error("awready and arready high together");

endmodule

`default_nettype wire

// File: logic/fir_sample_window.sv
`timescale 1ns/1ps
`default_nettype none

`include "fir_settings.svh"

module fir_sample_window import fir_pkg::*; (
  input  wire        axis_clk,
  input  wire        axis_rst_n,
  // input stream
  input  wire        ss_tvalid,
  input  wire word_t ss_tdata,
  input  wire        ss_tlast,
  output logic       ss_tready,
  input  wire        busy,
  // coefficient lookup
  output tap_idx_t   coef_idx,
  input  wire word_t coef,
  fir_mac_if.source  mac
);

  localparam int n_taps = `FIR_NUM_TAPS;
  localparam tap_idx_t last_idx = tap_idx_t'(n_taps - 1);

  word_t    hist [n_taps];  // circular sample history
  tap_idx_t head;           // next write slot
  tap_idx_t rd_ptr;         // slot of x[n-k]
  tap_idx_t k;
  logic     issuing;
  logic     busy_q;
  logic     frame_last_q;
  logic     take;
  logic     beat;

  // one idle cycle after start while history clears
  assign ss_tready = busy & busy_q & ~issuing;
  assign take      = ss_tvalid & ss_tready;
  assign beat      = mac.valid & mac.ready;

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) busy_q <= 1'b0;
    else busy_q <= busy;
  end

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      for (int i = 0; i < n_taps; i++) hist[i] <= '0;
      head <= '0;
    end else if (busy && !busy_q) begin
      for (int i = 0; i < n_taps; i++) hist[i] <= '0;  // new frame, no old samples
      head <= '0;
    end else if (take) begin
      hist[head] <= ss_tdata;
      head       <= (head == last_idx) ? '0 : head + 1'b1;
    end
  end

  // beat sequencer, k walks 0..n_taps-1
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      issuing      <= 1'b0;
      rd_ptr       <= '0;
      k            <= '0;
      frame_last_q <= 1'b0;
    end else if (take) begin
      issuing      <= 1'b1;
      rd_ptr       <= head;
      k            <= '0;
      frame_last_q <= ss_tlast;
    end else if (beat) begin
      rd_ptr <= (rd_ptr == '0) ? last_idx : rd_ptr - 1'b1;  // step back in time
      k      <= k + 1'b1;
      if (k == last_idx) issuing <= 1'b0;
    end
  end

  assign coef_idx       = k;
  assign mac.valid      = issuing;
  assign mac.sample     = hist[rd_ptr];
  assign mac.coef       = coef;
  assign mac.last_tap   = (k == last_idx);
  assign mac.frame_last = frame_last_q;

  a_beats_only_busy: assert property (
    @(posedge axis_clk) disable iff (!axis_rst_n) mac.valid |-> busy
  ) else $error("mac beat issued outside a run");

endmodule

`default_nettype wire

// File: logic/fir_mac.sv
`timescale 1ns/1ps
`default_nettype none

module fir_mac import fir_pkg::*; (
  input  wire       axis_clk,
  input  wire       axis_rst_n,
  fir_mac_if.sink   mac,
  // output stream
  output logic      sm_tvalid,
  output word_t     sm_tdata,
  output logic      sm_tlast,
  input  wire       sm_tready,
  output logic      frame_done
);

  word_t acc;
  word_t prod;
  word_t sum;
  logic  beat;
  logic  out_hold;

  assign prod = mac.sample * mac.coef;  // wraps to 32 bits
  assign sum  = acc + prod;

  // stall beats behind an unaccepted result
  assign out_hold  = sm_tvalid & ~sm_tready;
  assign mac.ready = ~out_hold;
  assign beat      = mac.valid & mac.ready;

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      acc <= '0;
    end else if (beat) begin
      acc <= mac.last_tap ? '0 : sum;
    end
  end

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      sm_tvalid <= 1'b0;
      sm_tlast  <= 1'b0;
    end else if (beat && mac.last_tap) begin
      sm_tvalid <= 1'b1;
      sm_tlast  <= mac.frame_last;
    end else if (sm_tready) begin
      sm_tvalid <= 1'b0;
      sm_tlast  <= 1'b0;
    end
  end

  always_ff @(posedge axis_clk) begin
    if (beat && mac.last_tap) sm_tdata <= sum;
  end

  assign frame_done = sm_tvalid & sm_tready & sm_tlast;  // end of frame seen downstream

  a_out_stable: assert property (
    @(posedge axis_clk) disable iff (!axis_rst_n)
      out_hold |=> $stable(sm_tdata) && $stable(sm_tlast)
  ) else $error("output changed while stalled");

endmodule

`default_nettype wire

// File: logic/fir_top.sv
`timescale 1ns/1ps
`default_nettype none

module fir_top import fir_pkg::*; (
  input  wire        axis_clk,
  input  wire        axis_rst_n,
  // register port
  input  wire        awvalid,
  input  wire addr_t awaddr,
  input  wire        wvalid,
  input  wire word_t wdata,
  output logic       awready,
  output logic       wready,
  input  wire        arvalid,
  input  wire addr_t araddr,
  output logic       arready,
  output logic       rvalid,
  output word_t      rdata,
  input  wire        rready,
  // sample stream in
  input  wire        ss_tvalid,
  input  wire word_t ss_tdata,
  input  wire        ss_tlast,
  output logic       ss_tready,
  // result stream out
  output logic       sm_tvalid,
  output word_t      sm_tdata,
  output logic       sm_tlast,
  input  wire        sm_tready
);

  tap_idx_t coef_idx;
  word_t    coef;
  logic     busy;
  logic     frame_done;

  fir_mac_if mac_if ();

  fir_cfg_regs cfg_i (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .awvalid    (awvalid),
    .awaddr     (awaddr),
    .wvalid     (wvalid),
    .wdata      (wdata),
    .awready    (awready),
    .wready     (wready),
    .arvalid    (arvalid),
    .araddr     (araddr),
    .arready    (arready),
    .rvalid     (rvalid),
    .rdata      (rdata),
    .rready     (rready),
    .coef_idx   (coef_idx),
    .coef       (coef),
    .frame_done (frame_done),
    .busy       (busy)
  );

  fir_sample_window window_i (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .ss_tvalid  (ss_tvalid),
    .ss_tdata   (ss_tdata),
    .ss_tlast   (ss_tlast),
    .ss_tready  (ss_tready),
    .busy       (busy),
    .coef_idx   (coef_idx),
    .coef       (coef),
    .mac        (mac_if.source)
  );

  fir_mac mac_i (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .mac        (mac_if.sink),
    .sm_tvalid  (sm_tvalid),
    .sm_tdata   (sm_tdata),
    .sm_tlast   (sm_tlast),
    .sm_tready  (sm_tready),
    .frame_done (frame_done)
  );

endmodule

`default_nettype wire

// File: verification/fir_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module fir_clk_gen #(
  parameter real period_ns  = 4.0,
  parameter int  rst_cycles = 4
) (
  output logic axis_clk,
  output logic axis_rst_n
);

  initial begin
    axis_clk = 1'b0;
    forever #(period_ns / 2.0) axis_clk = ~axis_clk;
  end

  // release 1 ns after a rising edge, away from both edges
  initial begin
    axis_rst_n = 1'b0;
    repeat (rst_cycles) @(posedge axis_clk);
    #1 axis_rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: verification/fir_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fir_settings.svh"

module fir_tb import fir_pkg::*; ();

  localparam int n_taps     = `FIR_NUM_TAPS;
  localparam int max_len    = 32;
  localparam int n_rows     = 5;
  localparam int bus_limit  = 50;   // cycles per register handshake
  localparam int beat_limit = 400;  // cycles per stream word

  localparam int mode_lfsr    = 0;
  localparam int mode_impulse = 1;  // c[3] = 1, output is x delayed by 3
  localparam int mode_ones    = 2;

  logic  axis_clk;
  logic  axis_rst_n;
  logic  awvalid;
  addr_t awaddr;
  logic  wvalid;
  word_t wdata;
  logic  awready;
  logic  wready;
  logic  arvalid;
  addr_t araddr;
  logic  arready;
  logic  rvalid;
  word_t rdata;
  logic  rready;
  logic  ss_tvalid;
  word_t ss_tdata;
  logic  ss_tlast;
  logic  ss_tready;
  logic  sm_tvalid;
  word_t sm_tdata;
  logic  sm_tlast;
  logic  sm_tready;

  // stimulus table: frame length, tap mode, stall chance in 16ths
  int row_len   [n_rows];
  int row_mode  [n_rows];
  int row_stall [n_rows];

  word_t       exp_taps [n_taps];
  word_t       samples  [max_len];
  word_t       exp_out  [max_len];
  logic [31:0] lfsr_state;
  int          accepted;
  int          tests;
  int          checks;
  int          errors;
  int          test_err0;

  fir_clk_gen clk_gen_i (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n)
  );

  fir_top dut_i (.*);

  // words taken downstream, counted on the same edge the DUT sees
  always @(posedge axis_clk) begin
    if (sm_tvalid && sm_tready) accepted <= accepted + 1;
  end

  // galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic word_t take_bits(int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = (v << 1) | word_t'(lfsr_state[0]);
    end
    return v;
  endfunction

  function automatic addr_t tap_addr(int i);
    return addr_t'(`FIR_REG_TAP_BASE + 4 * i);
  endfunction

  // y[n] = sum c[k] * x[n-k], samples before the frame are zero
  function automatic word_t fir_ref(int n);
    word_t acc;
    acc = '0;
    for (int k = 0; k < n_taps; k++) begin
      if (n - k >= 0) acc = acc + exp_taps[k] * samples[n - k];
    end
    return acc;
  endfunction

  task automatic set_row(int i, int len, int mode, int stall);
    row_len[i]   = len;
    row_mode[i]  = mode;
    row_stall[i] = stall;
  endtask

  task automatic check_word(string name, word_t exp, word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error at %t: %s expected %h got %h", $realtime, name, exp, act);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error at %t: %s expected %b got %b", $realtime, name, exp, act);
    end
  endtask

  task automatic timeout_stop(string what);
    $display("timeout at %t: %s never came", $realtime, what);
    $display("=== FAIL ===");
    $finish;
  endtask

  task automatic end_test(string name);
    tests++;
    if (errors == test_err0) $display("test %0d %s: ok", tests, name);
    else $display("test %0d %s: %0d errors", tests, name, errors - test_err0);
    test_err0 = errors;
  endtask

  // called and returns on a falling edge
  task automatic axi_write(addr_t addr, word_t data);
    int n;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    n = 0;
    while (!(awready && wready)) begin
      if (n == bus_limit) timeout_stop("awready/wready");
      else begin
        @(negedge axis_clk);
        n++;
      end
    end
    @(negedge axis_clk);  // write landed on the edge just passed
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  task automatic axi_read(addr_t addr, output word_t data);
    int n;
    araddr  = addr;
    arvalid = 1'b1;
    n = 0;
    while (!arready) begin
      if (n == bus_limit) timeout_stop("arready");
      else begin
        @(negedge axis_clk);
        n++;
      end
    end
    @(negedge axis_clk);
    arvalid = 1'b0;
    n = 0;
    while (!rvalid) begin
      if (n == bus_limit) timeout_stop("rvalid");
      else begin
        @(negedge axis_clk);
        n++;
      end
    end
    data   = rdata;
    rready = 1'b1;
    @(negedge axis_clk);
    rready = 1'b0;
  endtask

  task automatic expect_reg(addr_t addr, word_t exp, string name);
    word_t v;
    axi_read(addr, v);
    check_word(name, exp, v);
  endtask

  task automatic send_frame(int len);
    int n;
    for (int i = 0; i < len; i++) begin
      ss_tdata  = samples[i];
      ss_tlast  = (i == len - 1);
      ss_tvalid = 1'b1;
      n = 0;
      while (!ss_tready) begin
        if (n == beat_limit) timeout_stop("ss_tready");
        else begin
          @(negedge axis_clk);
          n++;
        end
      end
      @(negedge axis_clk);  // taken on the edge just passed
    end
    ss_tvalid = 1'b0;
    ss_tlast  = 1'b0;
  endtask

  task automatic collect_frame(int len, int stall);
    int got;
    int idle;
    got  = 0;
    idle = 0;
    while (got < len) begin
      if (idle == beat_limit) timeout_stop("sm_tvalid");
      else begin
        sm_tready = (take_bits(4) >= stall);
        if (sm_tvalid && sm_tready) begin
          check_word($sformatf("sm_tdata[%0d]", got), exp_out[got], sm_tdata);
          check_bit($sformatf("sm_tlast[%0d]", got), got == len - 1, sm_tlast);
          got++;
          idle = 0;
        end else begin
          idle++;
        end
        @(negedge axis_clk);
      end
    end
    sm_tready = 1'b1;
  endtask

  // taps and samples for one row, loaded while idle
  task automatic prepare_row(int r);
    for (int i = 0; i < n_taps; i++) begin
      case (row_mode[r])
        mode_impulse: exp_taps[i] = (i == 3) ? 32'd1 : 32'd0;
        mode_ones:    exp_taps[i] = 32'd1;
        default:      exp_taps[i] = take_bits(32);
      endcase
      axi_write(tap_addr(i), exp_taps[i]);
    end
    for (int i = 0; i < row_len[r]; i++) samples[i] = take_bits(32);
    for (int i = 0; i < row_len[r]; i++) exp_out[i] = fir_ref(i);
  endtask

  initial begin
    int n;
    $timeformat(-9, 1, " ns", 0);
    lfsr_state = 32'h6bf3_3df3;
    awvalid   = 1'b0;
    awaddr    = '0;
    wvalid    = 1'b0;
    wdata     = '0;
    arvalid   = 1'b0;
    araddr    = '0;
    rready    = 1'b0;
    ss_tvalid = 1'b0;
    ss_tdata  = '0;
    ss_tlast  = 1'b0;
    sm_tready = 1'b1;
    accepted  = 0;
    tests     = 0;
    checks    = 0;
    errors    = 0;
    test_err0 = 0;
    set_row(0, 16, mode_lfsr, 0);
    set_row(1, 5, mode_impulse, 6);
    set_row(2, 20, mode_ones, 8);
    set_row(3, 3, mode_lfsr, 11);  // shorter than the tap count
    set_row(4, 12, mode_lfsr, 4);

    n = 0;
    @(negedge axis_clk);
    while (!axis_rst_n) begin
      if (n == 20) timeout_stop("reset release");
      else begin
        @(negedge axis_clk);
        n++;
      end
    end

    expect_reg(`FIR_REG_AP_CTRL, 32'h4, "ap_ctrl");
    for (int i = 0; i < n_taps; i++) expect_reg(tap_addr(i), '0, $sformatf("tap[%0d]", i));
    expect_reg(12'h010, '1, "unmapped 0x010");
    expect_reg(12'h014, '1, "unmapped 0x014");
    expect_reg(tap_addr(n_taps), '1, "past last tap");
    expect_reg(12'h082, '1, "misaligned tap");
    end_test("reset values");

    for (int i = 0; i < n_taps; i++) begin
      exp_taps[i] = take_bits(32);
      axi_write(tap_addr(i), exp_taps[i]);
    end
    for (int i = 0; i < n_taps; i++) expect_reg(tap_addr(i), exp_taps[i], $sformatf("tap[%0d]", i));
    end_test("tap readback");

    for (int r = 0; r < n_rows; r++) begin
      prepare_row(r);
      axi_write(`FIR_REG_AP_CTRL, 32'h1);
      expect_reg(`FIR_REG_AP_CTRL, 32'h0, "ap_ctrl while busy");
      expect_reg(tap_addr(0), '1, "tap[0] while busy");
      axi_write(tap_addr(5), ~exp_taps[5]);  // dropped while busy
      accepted = 0;
      fork
        send_frame(row_len[r]);
        collect_frame(row_len[r], row_stall[r]);
      join
      expect_reg(`FIR_REG_AP_CTRL, 32'h6, "ap_ctrl after frame");
      expect_reg(`FIR_REG_AP_CTRL, 32'h4, "ap_ctrl second read");
      for (int i = 0; i < n_taps; i++) expect_reg(tap_addr(i), exp_taps[i], $sformatf("tap[%0d]", i));
      check_word("accepted words", word_t'(row_len[r]), word_t'(accepted));
      end_test($sformatf("frame row %0d len %0d stall %0d/16", r, row_len[r], row_stall[r]));
    end

    $display("tests %0d  checks %0d  errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+logic
logic/fir_pkg.sv
logic/fir_mac_if.sv
logic/fir_cfg_regs.sv
logic/fir_sample_window.sv
logic/fir_mac.sv
logic/fir_top.sv
verification/fir_clk_gen.sv
verification/fir_tb.sv
